/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module rv_exec_tb -o rv_exec_sim
	./obj_dir/rv_exec_sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_exec_pkg::exec_ctrl_t          ctrl,
  input  logic [rv_exec_pkg::xlen-1:0]     pc,
  input  logic [rv_exec_pkg::xlen-1:0]     rs1_data,
  input  logic [rv_exec_pkg::xlen-1:0]     rs2_data,
  output logic [rv_exec_pkg::xlen-1:0]     result,
  output logic                             zero,
  output logic                             br_taken
);
  import rv_exec_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] full_res;
  logic [31:0]     word_a;
  logic [31:0]     word_b;
  logic [31:0]     word_res;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            br_cond;

  assign op_a = (ctrl.op1_sel == sel_pc) ? pc : rs1_data;

  always_comb begin
    case (ctrl.op2_sel)
      sel_imm:  op_b = ctrl.imm;
      sel_four: op_b = xlen'(4);
      default:  op_b = rs2_data;
    endcase
  end

  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  always_comb begin
    case (ctrl.alu_op)
      alu_add:    full_res = op_a + op_b;
      alu_sub:    full_res = op_a - op_b;
      alu_sll:    full_res = op_a << op_b[5:0];
      alu_slt:    full_res = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu:   full_res = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:    full_res = op_a ^ op_b;
      alu_srl:    full_res = op_a >> op_b[5:0];
      alu_sra:    full_res = $signed(op_a) >>> op_b[5:0];
      alu_or:     full_res = op_a | op_b;
      alu_and:    full_res = op_a & op_b;
      alu_pass_b: full_res = op_b;
      default:    full_res = '0;
    endcase
  end

  // W forms work on the low half only.
  assign word_a = op_a[31:0];
  assign word_b = op_b[31:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_addw: word_res = word_a + word_b;
      alu_subw: word_res = word_a - word_b;
      alu_sllw: word_res = word_a << word_b[4:0];
      alu_srlw: word_res = word_a >> word_b[4:0];
      alu_sraw: word_res = $signed(word_a) >>> word_b[4:0];
      default:  word_res = '0;
    endcase
  end

  assign result = ctrl.alu_op[4] ? {{32{word_res[31]}}, word_res} : full_res;
  assign zero   = (result == '0);

  always_comb begin
    case (ctrl.br_op)
      br_beq:  br_cond = eq;
      br_bne:  br_cond = !eq;
      br_blt:  br_cond = lt_s;
      br_bge:  br_cond = !lt_s;
      br_bltu: br_cond = lt_u;
      br_bgeu: br_cond = !lt_u;
      default: br_cond = 1'b0;
    endcase
  end

  assign br_taken = ctrl.is_branch & br_cond;

endmodule

`default_nettype wire

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  logic [31:0]             instr,
  output rv_exec_pkg::exec_ctrl_t ctrl
);
  import rv_exec_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic            bad;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{52{instr[31]}}, instr[31:20]};
  assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
  assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    ctrl = '0;
    bad  = 1'b0;
    case (opcode)
      opc_op: begin
        ctrl.alu_op = alu_op_t'({1'b0, funct7[5], funct3});
        bad = !(funct7 == 7'b0000000 ||
                (funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5)));
      end
      opc_op_imm: begin
        ctrl.op2_sel = sel_imm;
        ctrl.imm     = imm_i;
        if (funct3 == 3'd1) begin
          ctrl.alu_op = alu_sll;
          bad = (instr[31:26] != 6'b000000);
        end else if (funct3 == 3'd5) begin
          ctrl.alu_op = instr[30] ? alu_sra : alu_srl;
          bad = (instr[31:26] != 6'b000000 && instr[31:26] != 6'b010000);
        end else begin
          ctrl.alu_op = alu_op_t'({2'b00, funct3});
        end
      end
      opc_op_32: begin
        ctrl.alu_op = alu_op_t'({1'b1, funct7[5], funct3});
        bad = !((funct7 == 7'b0000000 && (funct3 == 3'd0 || funct3 == 3'd1 || funct3 == 3'd5)) ||
                (funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5)));
      end
      opc_op_imm_32: begin
        ctrl.op2_sel = sel_imm;
        ctrl.imm     = imm_i;
        case (funct3)
          3'd0: ctrl.alu_op = alu_addw;
          3'd1: begin
            ctrl.alu_op = alu_sllw;
            bad = (funct7 != 7'b0000000);
          end
          3'd5: begin
            ctrl.alu_op = instr[30] ? alu_sraw : alu_srlw;
            bad = (funct7 != 7'b0000000 && funct7 != 7'b0100000);
          end
          default: bad = 1'b1;
        endcase
      end
      opc_lui: begin
        ctrl.op2_sel = sel_imm;
        ctrl.alu_op  = alu_pass_b;
        ctrl.imm     = imm_u;
      end
      opc_auipc: begin
        ctrl.op1_sel = sel_pc;
        ctrl.op2_sel = sel_imm;
        ctrl.imm     = imm_u;
      end
      opc_branch: begin
        // Result is rs1 - rs2, so zero reflects equality.
        ctrl.alu_op    = alu_sub;
        ctrl.is_branch = 1'b1;
        ctrl.br_op     = br_op_t'(funct3);
        ctrl.imm       = imm_b;
        bad = (funct3 == 3'd2 || funct3 == 3'd3);
      end
      opc_jal, opc_jalr: begin
        // Link value pc + 4 comes out of the ALU.
        ctrl.op1_sel = sel_pc;
        ctrl.op2_sel = sel_four;
        ctrl.is_jal  = (opcode == opc_jal);
        ctrl.is_jalr = (opcode == opc_jalr);
        ctrl.imm     = (opcode == opc_jal) ? imm_j : imm_i;
        bad = (opcode == opc_jalr && funct3 != 3'd0);
      end
      default: bad = 1'b1;
    endcase

    // Unknown encodings pass a zero immediate, so the result is zero.
    if (bad) begin
      ctrl         = '0;
      ctrl.op2_sel = sel_imm;
      ctrl.alu_op  = alu_pass_b;
      ctrl.illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_exec_hs.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_hs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  rv_exec_pkg::exec_rsp_t rsp_next,
  output logic                   ack,
  output rv_exec_pkg::exec_rsp_t rsp_data
);

  typedef enum logic {st_idle, st_busy} state_t;

  state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      rsp_data <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req) begin
            state    <= st_busy;
            rsp_data <= rsp_next;
          end
        end
        st_busy: begin
          // Wait for the requester to release req.
          if (!req) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign ack = (state == st_busy);

  // Ack comes up only after req was sampled high.
  a_ack_rise_with_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req)
  ) else $error("ack rose while req was low");

  a_rsp_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> $stable(rsp_data)
  ) else $error("rsp_data changed while ack was high");

endmodule

`default_nettype wire

/* rtl/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

  localparam int xlen = 64;

  // Major opcodes of the covered groups.
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;

  // Bit 4 marks a word operation, bit 3 the alternate funct7 form.
  typedef enum logic [4:0] {
    alu_add    = 5'b00000,
    alu_sll    = 5'b00001,
    alu_slt    = 5'b00010,
    alu_sltu   = 5'b00011,
    alu_xor    = 5'b00100,
    alu_srl    = 5'b00101,
    alu_or     = 5'b00110,
    alu_and    = 5'b00111,
    alu_sub    = 5'b01000,
    alu_sra    = 5'b01101,
    alu_pass_b = 5'b01111,
    alu_addw   = 5'b10000,
    alu_sllw   = 5'b10001,
    alu_srlw   = 5'b10101,
    alu_subw   = 5'b11000,
    alu_sraw   = 5'b11101
  } alu_op_t;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_op_t;

  typedef enum logic {sel_rs1, sel_pc} op1_sel_t;

  typedef enum logic [1:0] {sel_rs2, sel_imm, sel_four} op2_sel_t;

  typedef struct packed {
    op1_sel_t        op1_sel;
    op2_sel_t        op2_sel;
    alu_op_t         alu_op;
    logic            is_branch;
    br_op_t          br_op;
    logic            is_jal;
    logic            is_jalr;
    logic [xlen-1:0] imm;
    logic            illegal;
  } exec_ctrl_t;

  typedef struct packed {
    logic [31:0]     instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
  } exec_req_t;

  typedef struct packed {
    logic [xlen-1:0] result;
    logic            zero;
    logic            br_taken;
    logic [xlen-1:0] next_pc;
    logic            illegal;
  } exec_rsp_t;

endpackage

`default_nettype wire

/* rtl/rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  rv_exec_pkg::exec_req_t req_data,
  output logic                   ack,
  output rv_exec_pkg::exec_rsp_t rsp_data
);
  import rv_exec_pkg::*;

  exec_ctrl_t      ctrl;
  exec_rsp_t       rsp_next;
  logic [xlen-1:0] result;
  logic [xlen-1:0] next_pc;
  logic            zero;
  logic            br_taken;

  rv_decode u_decode (
    .instr (req_data.instr),
    .ctrl  (ctrl)
  );

  rv_alu u_alu (
    .ctrl     (ctrl),
    .pc       (req_data.pc),
    .rs1_data (req_data.rs1_data),
    .rs2_data (req_data.rs2_data),
    .result   (result),
    .zero     (zero),
    .br_taken (br_taken)
  );

  rv_next_pc u_next_pc (
    .ctrl     (ctrl),
    .pc       (req_data.pc),
    .rs1_data (req_data.rs1_data),
    .br_taken (br_taken),
    .next_pc  (next_pc)
  );

  assign rsp_next = '{result: result, zero: zero, br_taken: br_taken,
                      next_pc: next_pc, illegal: ctrl.illegal};

  rv_exec_hs u_hs (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .rsp_next (rsp_next),
    .ack      (ack),
    .rsp_data (rsp_data)
  );

endmodule

`default_nettype wire

/* rtl/rv_next_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_next_pc (
  input  rv_exec_pkg::exec_ctrl_t      ctrl,
  input  logic [rv_exec_pkg::xlen-1:0] pc,
  input  logic [rv_exec_pkg::xlen-1:0] rs1_data,
  input  logic                         br_taken,
  output logic [rv_exec_pkg::xlen-1:0] next_pc
);
  import rv_exec_pkg::*;

  logic [xlen-1:0] base;
  logic [xlen-1:0] target;

  // Own adder, the ALU is busy forming the link value.
  assign base   = ctrl.is_jalr ? rs1_data : pc;
  assign target = base + ctrl.imm;

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = {target[xlen-1:1], 1'b0};
    end else if (ctrl.is_jal || br_taken) begin
      next_pc = target;
    end else begin
      next_pc = pc + xlen'(4);
    end
  end

endmodule

`default_nettype wire

/* sim/rv_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;
  import rv_exec_pkg::*;

  localparam logic [63:0] pc0   = 64'h1000;
  localparam logic [63:0] ones  = 64'hffff_ffff_ffff_ffff;
  localparam logic [63:0] min64 = 64'h8000_0000_0000_0000;
  localparam logic [63:0] neg_w = 64'hffff_ffff_8000_0000;

  logic      clk;
  logic      rst_n;
  logic      req;
  exec_req_t req_data;
  logic      ack;
  exec_rsp_t rsp_data;

  string     names[$];
  exec_req_t reqs[$];
  exec_rsp_t exps[$];
  integer    seed;
  int        cycles;
  int        limit;
  int        passed;
  int        failed;
  int        errors;

  rv_exec_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp_data (rsp_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the req/ack exchange did not complete", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Register numbers are fixed because only the port operands matter.
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] opc);
    return {imm, 5'd1, f3, 5'd3, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, 7'b1101111};
  endfunction

  task automatic add_test(input string name, input logic [31:0] instr, input logic [63:0] pc,
                          input logic [63:0] rs1, input logic [63:0] rs2,
                          input logic [63:0] result, input logic br, input logic [63:0] npc,
                          input logic ill);
    exec_req_t r;
    exec_rsp_t e;
    r = '{instr: instr, pc: pc, rs1_data: rs1, rs2_data: rs2};
    e = '{result: result, zero: (result == 64'd0), br_taken: br, next_pc: npc, illegal: ill};
    names.push_back(name);
    reqs.push_back(r);
    exps.push_back(e);
  endtask

  task automatic add_alu(input string name, input logic [31:0] instr, input logic [63:0] rs1,
                         input logic [63:0] rs2, input logic [63:0] result);
    add_test(name, instr, pc0, rs1, rs2, result, 1'b0, pc0 + 64'd4, 1'b0);
  endtask

  // Branch entries use a target offset of 0x40 and a result of rs1 minus rs2.
  task automatic add_branch(input string name, input logic [2:0] f3, input logic [63:0] rs1,
                            input logic [63:0] rs2, input logic taken);
    add_test(name, b_type(13'h040, f3), pc0, rs1, rs2, rs1 - rs2, taken,
             taken ? pc0 + 64'h40 : pc0 + 64'd4, 1'b0);
  endtask

  task automatic build_table();
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] w;
    add_alu("add", r_type(7'h00, 3'd0, opc_op), 64'd5, 64'd7, 64'd12);
    add_alu("sub_zero", r_type(7'h20, 3'd0, opc_op), 64'd9, 64'd9, 64'd0);
    add_alu("and", r_type(7'h00, 3'd7, opc_op), 64'hf0f0, 64'h0ff0, 64'h00f0);
    add_alu("or", r_type(7'h00, 3'd6, opc_op), 64'hf000, 64'h000f, 64'hf00f);
    add_alu("xor", r_type(7'h00, 3'd4, opc_op), 64'hff, 64'h0f, 64'hf0);
    add_alu("slt_neg", r_type(7'h00, 3'd2, opc_op), ones, 64'd1, 64'd1);
    add_alu("sltu_neg", r_type(7'h00, 3'd3, opc_op), ones, 64'd1, 64'd0);
    add_alu("sll_63", r_type(7'h00, 3'd1, opc_op), 64'd1, 64'd63, min64);
    add_alu("srl_63", r_type(7'h00, 3'd5, opc_op), min64, 64'd63, 64'd1);
    add_alu("sra_63", r_type(7'h20, 3'd5, opc_op), min64, 64'd63, ones);
    add_alu("addi_neg", i_type(12'hffd, 3'd0, opc_op_imm), 64'd10, 64'd0, 64'd7);
    add_alu("slti_neg", i_type(12'hfff, 3'd2, opc_op_imm), 64'd0, 64'd0, 64'd0);
    add_alu("sltiu_neg", i_type(12'hfff, 3'd3, opc_op_imm), 64'd0, 64'd0, 64'd1);
    add_alu("srai_63", i_type(12'h43f, 3'd5, opc_op_imm), min64, 64'd0, ones);
    add_alu("xori", i_type(12'h0ff, 3'd4, opc_op_imm), 64'h0f0f, 64'd0, 64'h0ff0);
    add_alu("ori", i_type(12'h0f0, 3'd6, opc_op_imm), 64'h000f, 64'd0, 64'h00ff);
    add_alu("andi_neg", i_type(12'hff0, 3'd7, opc_op_imm), 64'h1234, 64'd0, 64'h1230);
    add_alu("slli_63", i_type(12'h03f, 3'd1, opc_op_imm), 64'd1, 64'd0, min64);
    add_alu("srli_63", i_type(12'h03f, 3'd5, opc_op_imm), min64, 64'd0, 64'd1);
    add_alu("addw_ovf", r_type(7'h00, 3'd0, opc_op_32), 64'h7fff_ffff, 64'd1, neg_w);
    add_alu("subw", r_type(7'h20, 3'd0, opc_op_32), 64'd0, 64'd1, ones);
    add_alu("sllw_31", r_type(7'h00, 3'd1, opc_op_32), 64'd1, 64'd31, neg_w);
    add_alu("srlw", r_type(7'h00, 3'd5, opc_op_32), neg_w, 64'd4, 64'h0800_0000);
    add_alu("sraw", r_type(7'h20, 3'd5, opc_op_32), 64'h8000_0000, 64'd4, 64'hffff_ffff_f800_0000);
    add_alu("addiw_ovf", i_type(12'h001, 3'd0, opc_op_imm_32), 64'h1_7fff_ffff, 64'd0, neg_w);
    add_alu("lui", {20'h80000, 5'd3, opc_lui}, 64'd0, 64'd0, neg_w);
    add_alu("auipc", {20'h00001, 5'd3, opc_auipc}, 64'd0, 64'd0, pc0 + 64'h1000);
    add_test("jal_fwd", j_type(21'h000100), pc0, 64'd0, 64'd0, pc0 + 64'd4, 1'b0,
             pc0 + 64'h100, 1'b0);
    add_test("jal_back", j_type(21'h1ffff8), pc0, 64'd0, 64'd0, pc0 + 64'd4, 1'b0,
             pc0 - 64'd8, 1'b0);
    add_test("jalr", i_type(12'h004, 3'd0, opc_jalr), pc0, 64'h2001, 64'd0, pc0 + 64'd4, 1'b0,
             64'h2004, 1'b0);
    add_branch("beq_taken", 3'd0, 64'd3, 64'd3, 1'b1);
    add_branch("beq_not", 3'd0, 64'd3, 64'd4, 1'b0);
    add_branch("bne_taken", 3'd1, 64'd3, 64'd4, 1'b1);
    add_branch("bne_not", 3'd1, 64'd3, 64'd3, 1'b0);
    add_branch("blt_taken", 3'd4, ones, 64'd1, 1'b1);
    add_branch("blt_not", 3'd4, 64'd1, ones, 1'b0);
    add_branch("bge_taken", 3'd5, 64'd1, ones, 1'b1);
    add_branch("bge_not", 3'd5, ones, 64'd1, 1'b0);
    add_branch("bltu_taken", 3'd6, 64'd1, ones, 1'b1);
    add_branch("bltu_not", 3'd6, ones, 64'd1, 1'b0);
    add_branch("bgeu_taken", 3'd7, ones, 64'd1, 1'b1);
    add_branch("bgeu_not", 3'd7, 64'd1, ones, 1'b0);
    add_test("illegal_zero", 32'h0, pc0, 64'h55, 64'h66, 64'd0, 1'b0, pc0 + 64'd4, 1'b1);
    add_test("illegal_mul", r_type(7'h01, 3'd0, opc_op), pc0, 64'd3, 64'd4, 64'd0, 1'b0,
             pc0 + 64'd4, 1'b1);
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    w = a[31:0] + b[31:0];
    add_alu("rand_add", r_type(7'h00, 3'd0, opc_op), a, b, a + b);
    add_alu("rand_sub", r_type(7'h20, 3'd0, opc_op), a, b, a - b);
    add_alu("rand_xor", r_type(7'h00, 3'd4, opc_op), a, b, a ^ b);
    add_alu("rand_addw", r_type(7'h00, 3'd0, opc_op_32), a, b, {{32{w[31]}}, w});
  endtask

  initial begin
    exec_rsp_t held;
    exec_rsp_t want;
    logic      val_ok;
    logic      hs_ok;
    rst_n    = 1'b0;
    req      = 1'b0;
    req_data = '0;
    cycles   = 0;
    limit    = 0;
    passed   = 0;
    failed   = 0;
    errors   = 0;
    seed     = 32'hc45e;
    build_table();
    limit = 16 + 12 * names.size() + 50;
    repeat (16) @(posedge clk);
    #1;
    if (ack !== 1'b0 || rsp_data !== '0) begin
      $display("ack or rsp_data was not cleared by reset");
      errors++;
    end
    rst_n = 1'b1;
    for (int i = 0; i < names.size(); i++) begin
      @(posedge clk);
      #1;
      req_data = reqs[i];
      req      = 1'b1;
      want     = exps[i];
      hs_ok    = 1'b1;
      val_ok   = 1'b1;
      @(posedge clk);
      #1;
      if (ack !== 1'b1) begin
        $display("%s: ack did not rise one cycle after req", names[i]);
        hs_ok = 1'b0;
        wait (ack === 1'b1);
        #1;
      end
      if (rsp_data.result !== want.result) val_ok = 1'b0;
      if (rsp_data.zero !== want.zero) val_ok = 1'b0;
      if (rsp_data.br_taken !== want.br_taken) val_ok = 1'b0;
      if (rsp_data.next_pc !== want.next_pc) val_ok = 1'b0;
      if (rsp_data.illegal !== want.illegal) val_ok = 1'b0;
      // Every tenth transaction holds req to check back-pressure.
      if (i % 10 == 0) begin
        held = rsp_data;
        // New operands during the hold must not reach the response register.
        req_data = '0;
        repeat (10) begin
          @(posedge clk);
          #1;
          if (ack !== 1'b1 || rsp_data !== held) begin
            $display("%s: ack or rsp_data changed while req was held high", names[i]);
            hs_ok = 1'b0;
          end
        end
      end
      req = 1'b0;
      @(posedge clk);
      #1;
      if (ack !== 1'b0) begin
        $display("%s: ack did not fall one cycle after req fell", names[i]);
        hs_ok = 1'b0;
        wait (ack === 1'b0);
      end
      if (!val_ok) begin
        $write("mismatch %s: expected res=%h z=%b br=%b npc=%h ill=%b", names[i],
               want.result, want.zero, want.br_taken, want.next_pc, want.illegal);
        $display(" actual res=%h z=%b br=%b npc=%h ill=%b", rsp_data.result, rsp_data.zero,
                 rsp_data.br_taken, rsp_data.next_pc, rsp_data.illegal);
        failed++;
      end else if (!hs_ok) begin
        $display("fail %s: handshake timing wrong", names[i]);
        failed++;
      end else begin
        $display("pass %s", names[i]);
        passed++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             names.size(), passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/rv_exec_pkg.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_next_pc.sv
rtl/rv_exec_hs.sv
rtl/rv_exec_top.sv
sim/rv_exec_tb.sv
